// File: vfmau_pkg.sv
//--------------------------------------------------------------------------
// Shared widths, the operand word union and the stage bundles of the vfmau
// multiply-accumulate pipe. Compiled ahead of every RTL file
//--------------------------------------------------------------------------
package vfmau_pkg;

  //------------------------------------------------------------------------
  // Widths
  //------------------------------------------------------------------------
  // Operand and result word
  localparam int WORD_W = 32;
  // One half-mode lane
  localparam int LANE_W = 16;
  // Half-mode multiplier input
  localparam int BYTE_W = 8;

  //------------------------------------------------------------------------
  // Operand word, read either whole or as two lanes
  //------------------------------------------------------------------------
  // Upper lane first so lane.hi sits on bits 31:16
  typedef struct packed {
    logic [LANE_W-1:0] hi;
    logic [LANE_W-1:0] lo;
  } vfmau_lanes_s;

  // Full view for 32-bit math, lane view for split math
  typedef union packed {
    logic [WORD_W-1:0] full;
    vfmau_lanes_s      lane;
  } vfmau_word_u;

  //------------------------------------------------------------------------
  // Stage bundles
  //------------------------------------------------------------------------
  // Issue fields, sampled on the edge where vld is high
  typedef struct packed {
    logic        vld;
    logic        half;
    logic        fma;
    vfmau_word_u src_a;
    vfmau_word_u src_b;
    vfmau_word_u src_c;
  } vfmau_issue_s;

  // Pipe-down pair of one stage boundary
  typedef struct packed {
    logic full_pipedown;
    logic half_pipedown;
  } vfmau_strobe_s;

  // Strobes for every boundary, from the control block
  typedef struct packed {
    vfmau_strobe_s ex12;
    vfmau_strobe_s ex23;
    vfmau_strobe_s ex34;
    vfmau_strobe_s ex45;
  } vfmau_pipe_s;

  // Half flag per datapath stage, back to the control block
  typedef struct packed {
    logic ex1;
    logic ex2;
    logic ex3;
    logic ex4;
  } vfmau_half_s;

endpackage

// File: vfmau_ctrl.sv
//--------------------------------------------------------------------------
// Valid chain EX1 to EX5 and the full/half pipe-down strobes of vfmau.
// Flush clears every stage; the datapath loads its registers on the strobes
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module vfmau_ctrl (
  input  logic                   ctrl_ex4_ex5_clk,
  input  logic                   cpurst_b,
  input  logic                   issue_vld,
  input  logic                   flush,
  input  vfmau_pkg::vfmau_half_s stage_half,
  output vfmau_pkg::vfmau_pipe_s pipe,
  output logic                   result_vld,
  output logic                   result_half
);
  import vfmau_pkg::*;

  logic       ex2_vld;
  logic       ex3_vld;
  logic       ex4_vld;
  logic       ex5_wb_vld;
  logic       ex5_half;
  logic [3:0] stage_vld;
  logic [3:0] prev_vld;
  logic [2:0] half_vld;
  logic [2:0] half_now;
  logic [2:0] half_prev;

  //------------------------------------------------------------------------
  // Pipe-down strobes
  //------------------------------------------------------------------------
  // EX1 valid is the issue strobe itself
  always_comb
  begin
    pipe.ex12.full_pipedown = issue_vld & ~stage_half.ex1;
    pipe.ex12.half_pipedown = issue_vld &  stage_half.ex1;
    pipe.ex23.full_pipedown = ex2_vld   & ~stage_half.ex2;
    pipe.ex23.half_pipedown = ex2_vld   &  stage_half.ex2;
    pipe.ex34.full_pipedown = ex3_vld   & ~stage_half.ex3;
    pipe.ex34.half_pipedown = ex3_vld   &  stage_half.ex3;
    pipe.ex45.full_pipedown = ex4_vld   & ~stage_half.ex4;
    pipe.ex45.half_pipedown = ex4_vld   &  stage_half.ex4;
  end

  //------------------------------------------------------------------------
  // Stage valids
  //------------------------------------------------------------------------
  // EX2 drops an issue that meets a flush
  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_vld <= 1'b0;
    else if (flush)
      ex2_vld <= 1'b0;
    else
      ex2_vld <= issue_vld;
  end

  // EX3
  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex3_vld <= 1'b0;
    else if (flush)
      ex3_vld <= 1'b0;
    else
      ex3_vld <= ex2_vld;
  end

  // EX4
  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex4_vld <= 1'b0;
    else if (flush)
      ex4_vld <= 1'b0;
    else
      ex4_vld <= ex3_vld;
  end

  //------------------------------------------------------------------------
  // EX5 writeback
  //------------------------------------------------------------------------
  // Any EX4 pipe-down ends in a writeback for MUL and FMA alike
  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex5_wb_vld <= 1'b0;
    else if (flush)
      ex5_wb_vld <= 1'b0;
    else
      ex5_wb_vld <= pipe.ex45.full_pipedown | pipe.ex45.half_pipedown;
  end

  // Mode of the word in the result register
  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex5_half <= 1'b0;
    else if (ex4_vld)
      ex5_half <= stage_half.ex4;
  end

  assign result_vld  = ex5_wb_vld;
  assign result_half = ex5_half;

  //------------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------------
  assign stage_vld = {ex5_wb_vld, ex4_vld, ex3_vld, ex2_vld};
  assign prev_vld  = {ex4_vld, ex3_vld, ex2_vld, issue_vld};
  assign half_vld  = {ex4_vld, ex3_vld, ex2_vld};
  assign half_now  = {stage_half.ex4, stage_half.ex3, stage_half.ex2};
  assign half_prev = {stage_half.ex3, stage_half.ex2, stage_half.ex1};

  // Datapath half flag moves down together with its valid
  a_half_follow: assert property (@(posedge ctrl_ex4_ex5_clk) disable iff (!cpurst_b)
    ((half_now ^ $past(half_prev)) & half_vld) == 3'b000)
    else $error("vfmau_ctrl: stage half flag does not match its operation");

  // Valid only moves down from a valid stage with no flush in between
  a_vld_chain: assert property (@(posedge ctrl_ex4_ex5_clk) disable iff (!cpurst_b)
    (stage_vld & ~$past(prev_vld & {4{~flush}})) == 4'b0000)
    else $error("vfmau_ctrl: stage valid without a valid source stage");

endmodule

// File: vfmau_pp_gen.sv
//--------------------------------------------------------------------------
// EX1 decode of the issue word and the EX1 to EX2 partial-product registers.
// A MUL enters with a zero addend, so later stages never look at the opcode
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module vfmau_pp_gen (
  input  logic                    ctrl_ex4_ex5_clk,
  input  logic                    cpurst_b,
  input  vfmau_pkg::vfmau_issue_s issue,
  input  vfmau_pkg::vfmau_pipe_s  pipe,
  output logic                    ex1_half,
  output logic                    ex2_half,
  output vfmau_pkg::vfmau_word_u  pp_lo,
  output vfmau_pkg::vfmau_word_u  pp_hi,
  output vfmau_pkg::vfmau_word_u  ex2_addend
);
  import vfmau_pkg::*;

  logic [LANE_W-1:0] full_a;
  logic [BYTE_W-1:0] full_b_lo;
  logic [BYTE_W-1:0] full_b_hi;
  vfmau_word_u       ex1_pp_lo;
  vfmau_word_u       ex1_pp_hi;
  vfmau_word_u       ex1_addend;
  logic              ex12_en;

  //------------------------------------------------------------------------
  // EX1 decode
  //------------------------------------------------------------------------
  assign ex1_half = issue.half;

  // Full mode uses the low lane of a and b as 16-bit operands
  assign full_a    = issue.src_a.lane.lo;
  assign full_b_lo = issue.src_b.lane.lo[BYTE_W-1:0];
  assign full_b_hi = issue.src_b.lane.lo[LANE_W-1:BYTE_W];

  // Low partial product or both lane byte products side by side
  always_comb
  begin
    ex1_pp_lo = '0;
    if (ex1_half)
    begin
      ex1_pp_lo.lane.lo = LANE_W'(issue.src_a.lane.lo[BYTE_W-1:0])
                        * LANE_W'(issue.src_b.lane.lo[BYTE_W-1:0]);
      ex1_pp_lo.lane.hi = LANE_W'(issue.src_a.lane.hi[BYTE_W-1:0])
                        * LANE_W'(issue.src_b.lane.hi[BYTE_W-1:0]);
    end
    else
      ex1_pp_lo.full = WORD_W'(full_a) * WORD_W'(full_b_lo);
  end

  // Upper byte of b at weight 2^8 for the EX2 fold
  assign ex1_pp_hi.full = WORD_W'(full_a) * WORD_W'(full_b_hi);

  // Zero addend turns MUL into FMA with c = 0
  assign ex1_addend = issue.fma ? issue.src_c : '0;

  //------------------------------------------------------------------------
  // EX1 to EX2
  //------------------------------------------------------------------------
  assign ex12_en = pipe.ex12.full_pipedown | pipe.ex12.half_pipedown;

  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_half <= 1'b0;
    else if (ex12_en)
      ex2_half <= ex1_half;
  end

  // Lane products and addend in either mode
  always_ff @(posedge ctrl_ex4_ex5_clk)
  begin
    if (ex12_en)
    begin
      pp_lo      <= ex1_pp_lo;
      ex2_addend <= ex1_addend;
    end
  end

  // Cross-lane partial product for full mode only
  always_ff @(posedge ctrl_ex4_ex5_clk)
  begin
    if (pipe.ex12.full_pipedown)
      pp_hi <= ex1_pp_hi;
  end

  // Half op leaves the upper partial product untouched
  a_hi_full_only: assert property (@(posedge ctrl_ex4_ex5_clk) disable iff (!cpurst_b)
    pipe.ex12.half_pipedown |=> $stable(pp_hi.full))
    else $error("vfmau_pp_gen: upper partial product loaded for a half op");

endmodule

// File: vfmau_pp_compress.sv
//--------------------------------------------------------------------------
// EX2 to EX3 partial-product summation. Full mode folds in the upper product
// one byte up; half mode keeps the two lane products apart
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module vfmau_pp_compress (
  input  logic                   ctrl_ex4_ex5_clk,
  input  logic                   cpurst_b,
  input  vfmau_pkg::vfmau_pipe_s pipe,
  input  logic                   ex2_half,
  input  vfmau_pkg::vfmau_word_u pp_lo,
  input  vfmau_pkg::vfmau_word_u pp_hi,
  input  vfmau_pkg::vfmau_word_u ex2_addend,
  output logic                   ex3_half,
  output vfmau_pkg::vfmau_word_u product,
  output vfmau_pkg::vfmau_word_u ex3_addend
);
  import vfmau_pkg::*;

  vfmau_word_u pp_hi_shift;
  vfmau_word_u ex2_product;
  logic        ex23_en;

  //------------------------------------------------------------------------
  // EX2 summation
  //------------------------------------------------------------------------
  // Upper product carries weight 2^8
  assign pp_hi_shift.full = {pp_hi.full[WORD_W-BYTE_W-1:0], {BYTE_W{1'b0}}};

  // Half mode has no add at all, so no carry crosses lanes
  // pp_hi is stale in half mode and never selected
  always_comb
  begin
    if (ex2_half)
      ex2_product = pp_lo;
    else
      ex2_product.full = pp_lo.full + pp_hi_shift.full;
  end

  //------------------------------------------------------------------------
  // EX2 to EX3
  //------------------------------------------------------------------------
  assign ex23_en = pipe.ex23.full_pipedown | pipe.ex23.half_pipedown;

  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex3_half <= 1'b0;
    else if (ex23_en)
      ex3_half <= ex2_half;
  end

  // Product and addend move together
  always_ff @(posedge ctrl_ex4_ex5_clk)
  begin
    if (ex23_en)
    begin
      product    <= ex2_product;
      ex3_addend <= ex2_addend;
    end
  end

endmodule

// File: vfmau_acc_wb.sv
//--------------------------------------------------------------------------
// Addend accumulate at EX3 to EX4 and the result register at EX4 to EX5.
// The lane carry is held apart in EX4 and only full mode folds it in
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module vfmau_acc_wb (
  input  logic                   ctrl_ex4_ex5_clk,
  input  logic                   cpurst_b,
  input  vfmau_pkg::vfmau_pipe_s pipe,
  input  logic                   ex3_half,
  input  vfmau_pkg::vfmau_word_u product,
  input  vfmau_pkg::vfmau_word_u ex3_addend,
  output logic                   ex4_half,
  output vfmau_pkg::vfmau_word_u result
);
  import vfmau_pkg::*;

  logic [LANE_W:0]   lo_sum;
  logic [LANE_W-1:0] hi_sum;
  vfmau_word_u       ex4_sum;
  logic              ex4_carry;
  logic              ex34_en;

  //------------------------------------------------------------------------
  // EX3 lane adders
  //------------------------------------------------------------------------
  // Low lane keeps its carry out for the full-mode fold
  assign lo_sum = {1'b0, product.lane.lo} + {1'b0, ex3_addend.lane.lo};
  // High lane without the low-lane carry
  assign hi_sum = product.lane.hi + ex3_addend.lane.hi;

  //------------------------------------------------------------------------
  // EX3 to EX4
  //------------------------------------------------------------------------
  assign ex34_en = pipe.ex34.full_pipedown | pipe.ex34.half_pipedown;

  always_ff @(posedge ctrl_ex4_ex5_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex4_half <= 1'b0;
    else if (ex34_en)
      ex4_half <= ex3_half;
  end

  // Both lane sums, either mode
  always_ff @(posedge ctrl_ex4_ex5_clk)
  begin
    if (ex34_en)
    begin
      ex4_sum.lane.hi <= hi_sum;
      ex4_sum.lane.lo <= lo_sum[LANE_W-1:0];
    end
  end

  // Upper carry, only a full op ever reads it
  always_ff @(posedge ctrl_ex4_ex5_clk)
  begin
    if (pipe.ex34.full_pipedown)
      ex4_carry <= lo_sum[LANE_W];
  end

  //------------------------------------------------------------------------
  // EX4 to EX5 result
  //------------------------------------------------------------------------
  // Full op finishes the 32-bit add, half op drops the carry
  always_ff @(posedge ctrl_ex4_ex5_clk)
  begin
    if (pipe.ex45.full_pipedown)
    begin
      result.lane.hi <= ex4_sum.lane.hi + LANE_W'(ex4_carry);
      result.lane.lo <= ex4_sum.lane.lo;
    end
    else if (pipe.ex45.half_pipedown)
      result <= ex4_sum;
  end

endmodule

// File: vfmau_top.sv
//--------------------------------------------------------------------------
// Top level of the vfmau pipe. Wires the control block to the three
// datapath stages; one result per cycle, 4 cycles after issue
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module vfmau_top (
  input  logic                    ctrl_ex4_ex5_clk,
  input  logic                    cpurst_b,
  input  vfmau_pkg::vfmau_issue_s issue,
  input  logic                    flush,
  output logic                    result_vld,
  output logic                    result_half,
  output vfmau_pkg::vfmau_word_u  result
);
  import vfmau_pkg::*;

  vfmau_pipe_s pipe;
  vfmau_half_s stage_half;
  logic        ex1_half;
  logic        ex2_half;
  logic        ex3_half;
  logic        ex4_half;
  vfmau_word_u pp_lo;
  vfmau_word_u pp_hi;
  vfmau_word_u ex2_addend;
  vfmau_word_u product;
  vfmau_word_u ex3_addend;

  // Half flags from each datapath stage back to control
  assign stage_half = '{ex1: ex1_half, ex2: ex2_half, ex3: ex3_half, ex4: ex4_half};

  //------------------------------------------------------------------------
  // Control
  //------------------------------------------------------------------------
  vfmau_ctrl i_ctrl (
    .ctrl_ex4_ex5_clk (ctrl_ex4_ex5_clk),
    .cpurst_b         (cpurst_b),
    .issue_vld        (issue.vld),
    .flush            (flush),
    .stage_half       (stage_half),
    .pipe             (pipe),
    .result_vld       (result_vld),
    .result_half      (result_half)
  );

  //------------------------------------------------------------------------
  // Datapath
  //------------------------------------------------------------------------
  // EX1 decode and partial products
  vfmau_pp_gen i_pp_gen (
    .ctrl_ex4_ex5_clk (ctrl_ex4_ex5_clk),
    .cpurst_b         (cpurst_b),
    .issue            (issue),
    .pipe             (pipe),
    .ex1_half         (ex1_half),
    .ex2_half         (ex2_half),
    .pp_lo            (pp_lo),
    .pp_hi            (pp_hi),
    .ex2_addend       (ex2_addend)
  );

  // EX2 product summation
  vfmau_pp_compress i_pp_compress (
    .ctrl_ex4_ex5_clk (ctrl_ex4_ex5_clk),
    .cpurst_b         (cpurst_b),
    .pipe             (pipe),
    .ex2_half         (ex2_half),
    .pp_lo            (pp_lo),
    .pp_hi            (pp_hi),
    .ex2_addend       (ex2_addend),
    .ex3_half         (ex3_half),
    .product          (product),
    .ex3_addend       (ex3_addend)
  );

  // EX3 accumulate, EX4 writeback register
  vfmau_acc_wb i_acc_wb (
    .ctrl_ex4_ex5_clk (ctrl_ex4_ex5_clk),
    .cpurst_b         (cpurst_b),
    .pipe             (pipe),
    .ex3_half         (ex3_half),
    .product          (product),
    .ex3_addend       (ex3_addend),
    .ex4_half         (ex4_half),
    .result           (result)
  );

endmodule

// File: tb_vfmau.sv
//--------------------------------------------------------------------------
// Testbench for the vfmau pipe. Applies a table of directed and random rows,
// one per clock, and checks every writeback against a reference model
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_vfmau;
  import vfmau_pkg::*;

  localparam int N_RANDOM    = 300;
  localparam int DRAIN_LIMIT = 16;
  // Rising edge of the drive to the cycle where the result is visible
  localparam int LATENCY     = 4;

  // One table row, expected word filled in by the model
  typedef struct packed {
    logic        issue;
    logic        half;
    logic        fma;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic        flush;
    logic [31:0] exp_word;
  } row_s;

  // Scoreboard entry, tagged with its due cycle
  typedef struct packed {
    logic [31:0] due;
    logic        half;
    logic [31:0] word;
  } exp_s;

  logic         ctrl_ex4_ex5_clk;
  logic         cpurst_b;
  vfmau_issue_s issue;
  logic         flush;
  logic         result_vld;
  logic         result_half;
  vfmau_word_u  result;

  row_s row_q[$];
  exp_s exp_q[$];
  row_s idle_row;
  int   cyc;
  int   drain_cycles;
  int   mismatch_cnt;
  int   missing_cnt;
  int   extra_cnt;
  int   timeout_cnt;
  int   results_seen;

  vfmau_top i_dut (
    .ctrl_ex4_ex5_clk (ctrl_ex4_ex5_clk),
    .cpurst_b         (cpurst_b),
    .issue            (issue),
    .flush            (flush),
    .result_vld       (result_vld),
    .result_half      (result_half),
    .result           (result)
  );

  // 100 ns clock
  always #50 ctrl_ex4_ex5_clk = ~ctrl_ex4_ex5_clk;

  //------------------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------------------
  // Full: a[15:0]*b[15:0]+c mod 2^32; half: per lane byte product + lane c
  function automatic logic [31:0] model_result(input logic half, input logic fma,
      input logic [31:0] a, input logic [31:0] b, input logic [31:0] c);
    logic [31:0] addend;
    logic [63:0] full_sum;
    logic [31:0] lo_sum;
    logic [31:0] hi_sum;
    begin
      addend   = fma ? c : 32'h0;
      full_sum = 64'(a[15:0]) * 64'(b[15:0]) + 64'(addend);
      lo_sum   = 32'(a[7:0]) * 32'(b[7:0]) + 32'(addend[15:0]);
      hi_sum   = 32'(a[23:16]) * 32'(b[23:16]) + 32'(addend[31:16]);
      if (half)
        model_result = {hi_sum[15:0], lo_sum[15:0]};
      else
        model_result = full_sum[31:0];
    end
  endfunction

  //------------------------------------------------------------------------
  // Table
  //------------------------------------------------------------------------
  function automatic void add_row(input logic issue_bit, input logic half,
      input logic fma, input logic [31:0] a, input logic [31:0] b,
      input logic [31:0] c, input logic flush_bit);
    row_s row;
    begin
      row.issue    = issue_bit;
      row.half     = half;
      row.fma      = fma;
      row.a        = a;
      row.b        = b;
      row.c        = c;
      row.flush    = flush_bit;
      row.exp_word = model_result(half, fma, a, b, c);
      row_q.push_back(row);
    end
  endfunction

  function automatic void add_idle(input int n);
    for (int i = 0; i < n; i++)
      add_row(1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0);
  endfunction

  function automatic void build_table();
    // Quiet pipe after reset
    add_idle(4);
    // Full MUL and FMA, wraparound, upper operand bits ignored
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_1234, 32'h0000_5678, 32'h0, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_ffff, 32'h0000_ffff, 32'hffff_ffff, 1'b0);
    add_row(1'b1, 1'b0, 1'b1, 32'h0000_ffff, 32'h0000_ffff, 32'h0002_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b1, 32'hdead_0003, 32'hbeef_0005, 32'h0000_0010, 1'b0);
    add_idle(4);
    // Half mode, overflow in one lane only
    add_row(1'b1, 1'b1, 1'b0, 32'h0012_0034, 32'h0003_0002, 32'h0, 1'b0);
    add_row(1'b1, 1'b1, 1'b1, 32'h0001_00ff, 32'h0001_00ff, 32'h0005_1000, 1'b0);
    add_row(1'b1, 1'b1, 1'b1, 32'h00ff_0002, 32'h00ff_0003, 32'h2000_fff0, 1'b0);
    add_row(1'b1, 1'b1, 1'b0, 32'hab10_cd20, 32'hef02_9904, 32'h1234_5678, 1'b0);
    add_idle(4);
    // Back-to-back mixed modes
    for (int i = 0; i < 8; i++)
      add_row(1'b1, 1'(i % 2), 1'(i / 2 % 2), 32'h0101_0101 * i + 32'h00f3_00e7,
              32'h0202_0303 * i + 32'h00c1_00d5, 32'hf00f_0ff0 + i, 1'b0);
    add_idle(4);
    // Flush kills everything in flight and its own issue
    add_row(1'b1, 1'b0, 1'b1, 32'h0000_0102, 32'h0000_0304, 32'h0000_0001, 1'b0);
    add_row(1'b1, 1'b1, 1'b1, 32'h0005_0006, 32'h0007_0008, 32'h0001_0001, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_7777, 32'h0000_0002, 32'h0, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_9999, 32'h0000_0003, 32'h0, 1'b1);
    // Next issue after the flush runs normally
    add_row(1'b1, 1'b0, 1'b1, 32'h0000_0010, 32'h0000_0020, 32'h0000_0005, 1'b0);
    add_idle(6);
    // Random rows, occasional flush
    for (int i = 0; i < N_RANDOM; i++)
      add_row($urandom_range(3) != 0, 1'($urandom_range(1)), 1'($urandom_range(1)),
              $urandom, $urandom, $urandom, $urandom_range(39) == 0);
    add_idle(2);
  endfunction

  //------------------------------------------------------------------------
  // Drive and check
  //------------------------------------------------------------------------
  // Output check at the falling edge, where outputs are settled
  task automatic check_outputs();
    exp_s ent;
    logic due_now;
    begin
      due_now = (exp_q.size() > 0) && (exp_q[0].due == cyc);
      if (due_now)
      begin
        ent = exp_q.pop_front();
        results_seen++;
        assert (result_vld === 1'b1)
        else
        begin
          $display("missing result: operation due in cycle %0d never arrived", cyc);
          missing_cnt++;
        end
        if (result_vld === 1'b1)
        begin
          assert (result_half === ent.half)
          else
          begin
            $display("mismatch result_half: got %h expected %h", result_half, ent.half);
            mismatch_cnt++;
          end
          assert (result.full === ent.word)
          else
          begin
            $display("mismatch result: got %08h expected %08h", result.full, ent.word);
            mismatch_cnt++;
          end
        end
      end
      else
      begin
        assert (result_vld === 1'b0)
        else
        begin
          $display("unexpected result: result_vld high with nothing due in cycle %0d", cyc);
          extra_cnt++;
        end
      end
    end
  endtask

  // One table row per rising edge
  task automatic apply_row(input row_s row);
    vfmau_issue_s nxt;
    exp_s         ent;
    begin
      @(posedge ctrl_ex4_ex5_clk);
      cyc = cyc + 1;
      nxt.vld        = row.issue;
      nxt.half       = row.half;
      nxt.fma        = row.fma;
      nxt.src_a.full = row.a;
      nxt.src_b.full = row.b;
      nxt.src_c.full = row.c;
      issue <= nxt;
      flush <= row.flush;
      if (row.flush)
      begin
        // Anything visible from the next cycle on is lost
        while (exp_q.size() > 0 && exp_q[$].due > cyc)
          void'(exp_q.pop_back());
      end
      else if (row.issue)
      begin
        ent.due  = cyc + LATENCY;
        ent.half = row.half;
        ent.word = row.exp_word;
        exp_q.push_back(ent);
      end
      @(negedge ctrl_ex4_ex5_clk);
      check_outputs();
    end
  endtask

  //------------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------------
  initial
  begin
    ctrl_ex4_ex5_clk = 1'b0;
    cpurst_b         = 1'b0;
    issue            = '0;
    flush            = 1'b0;
    idle_row         = '0;
    cyc              = 0;
    mismatch_cnt     = 0;
    missing_cnt      = 0;
    extra_cnt        = 0;
    timeout_cnt      = 0;
    results_seen     = 0;
    void'($urandom(32'h3a8193ed));
    build_table();

    repeat (3) @(posedge ctrl_ex4_ex5_clk);
    cpurst_b <= 1'b1;

    foreach (row_q[i])
      apply_row(row_q[i]);

    // Drain what is still in flight
    drain_cycles = 0;
    while (exp_q.size() > 0 && drain_cycles < DRAIN_LIMIT)
    begin
      apply_row(idle_row);
      drain_cycles++;
    end
    if (exp_q.size() > 0)
    begin
      $display("timeout: %0d results still outstanding after the drain", exp_q.size());
      timeout_cnt++;
    end
    // Pipe stays quiet afterwards
    repeat (3) apply_row(idle_row);

    $display("errors: mismatch %0d, missing %0d, unexpected %0d, timeout %0d (%0d results)",
             mismatch_cnt, missing_cnt, extra_cnt, timeout_cnt, results_seen);
    if (mismatch_cnt + missing_cnt + extra_cnt + timeout_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: build.f
vfmau_pkg.sv
vfmau_ctrl.sv
vfmau_pp_gen.sv
vfmau_pp_compress.sv
vfmau_acc_wb.sv
vfmau_top.sv
tb_vfmau.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the vfmau testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_vfmau -f build.f \
  --Mdir obj_dir -o sim_vfmau
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_vfmau > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
